// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing -Wno-fatal
TOP    = tb_uart_cmd_bridge
FLIST  = project.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^All checks passed$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: common/cmd_pkg.sv
package cmd_pkg;

  // host view of the command word, bit 15 selects write.
  typedef struct packed {
    logic                 wr;
    logic [6:0]           addr;
    uart_pkg::uart_byte_t data;
  } cmd_fields_t;

  // serial view, low byte goes out first.
  typedef struct packed {
    uart_pkg::uart_byte_t hi;
    uart_pkg::uart_byte_t lo;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_t;

  typedef struct packed {
    uart_pkg::uart_byte_t data;
    logic                 parity_err;
    logic                 frame_err;
  } read_result_t;

endpackage

// File: common/uart_pkg.sv
package uart_pkg;

  // fixed character width.
  localparam int data_bits = 8;

  // start, data, parity and stop.
  localparam int frame_bits = data_bits + 3;

  typedef logic [data_bits-1:0] uart_byte_t;

  // one received character with its line checks.
  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;
    logic       frame_err;
  } rx_status_t;

endpackage

// File: logic/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer #(
  parameter int gap_cycles = 100
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cmd_pkg::cmd_word_t    cmd,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic                  tx_start,
  output uart_pkg::uart_byte_t  tx_data,
  input  logic                  tx_done,
  input  logic                  rx_valid,
  input  uart_pkg::rx_status_t  rx_status,
  output logic                  read_rdy,
  output cmd_pkg::read_result_t read_result
);

  localparam int gap_w = $clog2(gap_cycles + 1);
  localparam logic [gap_w-1:0] gap_last = gap_w'(gap_cycles - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_send_lo,
    st_gap,
    st_send_hi,
    st_rsp_gap,
    st_wait_rsp,
    st_report
  } seq_state_t;

  seq_state_t         state;
  cmd_pkg::cmd_word_t cmd_q;
  logic [gap_w-1:0]   gap_cnt;
  logic               accept;
  logic               gap_end;

  // report cycle already counts as idle for the host.
  assign cmd_rdy  = (state == st_idle) || (state == st_report);
  assign read_rdy = (state == st_report);
  assign accept   = cmd_vld && cmd_rdy;
  assign gap_end  = (gap_cnt == gap_last);
  assign tx_data  = (state == st_send_hi) ? cmd_q.bytes.hi : cmd_q.bytes.lo;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      gap_cnt  <= '0;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        st_idle, st_report:
        begin
          if (accept)
          begin
            state    <= st_send_lo;
            tx_start <= 1'b1;
          end
          else
            state <= st_idle;
        end
        st_send_lo:
        begin
          if (tx_done)
          begin
            state   <= st_gap;
            gap_cnt <= '0;
          end
        end
        st_gap:
        begin
          if (gap_end)
          begin
            state    <= st_send_hi;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        st_send_hi:
        begin
          if (tx_done)
          begin
            if (cmd_q.fields.wr)
              state <= st_idle;
            else
            begin
              state   <= st_rsp_gap;
              gap_cnt <= '0;
            end
          end
        end
        st_rsp_gap:
        begin
          if (gap_end)
            state <= st_wait_rsp;
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        st_wait_rsp:
        begin
          // no timeout here.
          if (rx_valid)
            state <= st_report;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
    if (state == st_wait_rsp && rx_valid)
    begin
      read_result.data       <= rx_status.data;
      read_result.parity_err <= rx_status.parity_err;
      read_result.frame_err  <= rx_status.frame_err;
    end
  end

endmodule

// File: logic/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int clks_per_bit = 434,
  parameter int gap_cycles   = 100
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cmd_pkg::cmd_word_t    cmd,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  rx,
  output logic                  tx,
  output logic                  read_rdy,
  output cmd_pkg::read_result_t read_result
);

  logic                 tx_start;
  uart_pkg::uart_byte_t tx_data;
  logic                 tx_done;
  logic                 rx_valid;
  uart_pkg::rx_status_t rx_status;

  cmd_sequencer #(
    .gap_cycles (gap_cycles)
  ) u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .tx_done     (tx_done),
    .rx_valid    (rx_valid),
    .rx_status   (rx_status),
    .read_rdy    (read_rdy),
    .read_result (read_result)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // receiver runs freely, the sequencer picks what it needs.
  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_valid  (rx_valid),
    .rx_status (rx_status)
  );

endmodule

// File: project.f
common/uart_pkg.sv
common/cmd_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
logic/cmd_sequencer.sv
logic/uart_cmd_bridge.sv
verif/uart_line_model.sv
verif/tb_uart_cmd_bridge.sv

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 rx_valid,
  output uart_pkg::rx_status_t rx_status
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
  localparam int idx_w = $clog2(uart_pkg::frame_bits);
  // sample positions counted from the first data bit.
  localparam logic [idx_w-1:0] par_idx = idx_w'(uart_pkg::data_bits);
  localparam logic [idx_w-1:0] stop_idx = idx_w'(uart_pkg::data_bits + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_bits
  } rx_state_t;

  rx_state_t            state;
  logic [1:0]           sync;
  logic                 rx_d;
  logic                 fall;
  logic                 sample;
  logic [cnt_w-1:0]     bit_cnt;
  logic [idx_w-1:0]     bit_idx;
  uart_pkg::uart_byte_t shreg;
  logic                 par_bit;

  assign fall   = rx_d & ~sync[1];
  // half a bit into the start bit, then one bit time apart.
  assign sample = (state == st_start) ? (bit_cnt == half_cnt) : (bit_cnt == last_cnt);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync     <= 2'b11;
      rx_d     <= 1'b1;
      state    <= st_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      sync     <= {sync[0], rx};
      rx_d     <= sync[1];
      rx_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          if (fall)
          begin
            state   <= st_start;
            bit_cnt <= '0;
          end
        end
        st_start:
        begin
          if (sample)
          begin
            bit_cnt <= '0;
            bit_idx <= '0;
            // high again mid start bit, so only a glitch.
            state   <= sync[1] ? st_idle : st_bits;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        st_bits:
        begin
          if (sample)
          begin
            bit_cnt <= '0;
            if (bit_idx == stop_idx)
            begin
              state    <= st_idle;
              rx_valid <= 1'b1;
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_bits && sample)
    begin
      if (bit_idx < par_idx)
        shreg <= {sync[1], shreg[uart_pkg::data_bits-1:1]};
      else if (bit_idx == par_idx)
        par_bit <= sync[1];
      else
      begin
        rx_status.data       <= shreg;
        rx_status.parity_err <= ~^{shreg, par_bit};
        rx_status.frame_err  <= ~sync[1];
      end
    end
  end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 434
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx_start,
  input  uart_pkg::uart_byte_t tx_data,
  output logic                 tx_done,
  output logic                 tx
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
  localparam int idx_w = $clog2(uart_pkg::frame_bits);
  localparam logic [idx_w-1:0] stop_idx = idx_w'(uart_pkg::frame_bits - 1);

  logic                            busy;
  logic [cnt_w-1:0]                bit_cnt;
  logic [idx_w-1:0]                bit_idx;
  logic [uart_pkg::frame_bits-2:0] shreg;
  logic                            bit_end;

  assign bit_end = busy && (bit_cnt == last_cnt);
  // last cycle of the stop bit.
  assign tx_done = bit_end && (bit_idx == stop_idx);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (!busy)
    begin
      if (tx_start)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
        tx      <= 1'b0;
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == stop_idx)
        busy <= 1'b0;
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  // stop and odd parity sit above the data, shifted out lsb first.
  always_ff @(posedge clk)
  begin
    if (!busy && tx_start)
      shreg <= {1'b1, ~^tx_data, tx_data};
    else if (bit_end)
      shreg <= {1'b1, shreg[uart_pkg::frame_bits-2:1]};
  end

endmodule

// File: verif/tb_uart_cmd_bridge.sv
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int clks_per_bit = 16;
  localparam int gap_cycles   = 8;
  localparam int max_cases    = 64;

  typedef struct packed {
    logic                 start;
    uart_pkg::uart_byte_t data;
    logic                 par;
    logic                 stop;
  } line_frame_t;

  logic                  clk;
  logic                  rst_n;
  cmd_pkg::cmd_word_t    cmd;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic                  read_rdy;
  cmd_pkg::read_result_t read_result;

  uart_pkg::uart_byte_t  rsp_byte;
  logic [1:0]            rsp_code;
  logic                  frame_vld;
  logic                  frame_start;
  uart_pkg::uart_byte_t  frame_data;
  logic                  frame_par;
  logic                  frame_stop;

  logic [19:0]           stim_mem [0:3*max_cases-1];
  line_frame_t           frame_q [$];
  cmd_pkg::read_result_t read_q [$];
  int                    num_cases;
  int                    cycles;
  int                    cycle_limit;

  uart_cmd_bridge #(
    .clks_per_bit (clks_per_bit),
    .gap_cycles   (gap_cycles)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx),
    .tx          (tx),
    .read_rdy    (read_rdy),
    .read_result (read_result)
  );

  uart_line_model #(
    .clks_per_bit (clks_per_bit)
  ) peer (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx          (tx),
    .rx          (rx),
    .rsp_byte    (rsp_byte),
    .rsp_code    (rsp_code),
    .frame_vld   (frame_vld),
    .frame_start (frame_start),
    .frame_data  (frame_data),
    .frame_par   (frame_par),
    .frame_stop  (frame_stop)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                            input uart_pkg::uart_byte_t exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_read(input string name, input cmd_pkg::read_result_t got,
                            input cmd_pkg::read_result_t exp);
    if (got !== exp)
      abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // parity bit that makes the count of ones odd.
  function automatic logic odd_parity(input uart_pkg::uart_byte_t data);
    int ones;
    ones = 0;
    for (int i = 0; i < uart_pkg::data_bits; i++)
    begin
      if (data[i])
        ones++;
    end
    return (ones % 2 == 0);
  endfunction

  task automatic check_frame(input string name, input uart_pkg::uart_byte_t exp_data);
    line_frame_t got;
    got = frame_q.pop_front();
    check_level({name, " start"}, got.start, 1'b0);
    check_byte({name, " data"}, got.data, exp_data);
    check_level({name, " parity"}, got.par, odd_parity(exp_data));
    check_level({name, " stop"}, got.stop, 1'b1);
  endtask

  task automatic expect_quiet(input string where);
    if (frame_q.size() != 0)
      abort_run($sformatf("unexpected frame on tx %s", where));
    if (read_q.size() != 0)
      abort_run($sformatf("unexpected read_rdy pulse %s", where));
  endtask

  // frames land on the rising edge, read results on the falling edge.
  always @(posedge clk)
  begin
    if (frame_vld)
      frame_q.push_back({frame_start, frame_data, frame_par, frame_stop});
  end

  always @(negedge clk)
  begin
    if (read_rdy)
      read_q.push_back(read_result);
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
      abort_run($sformatf("run did not finish within %0d cycles", cycle_limit));
  end

  initial
  begin : main
    cmd_pkg::cmd_word_t    cmd_word;
    uart_pkg::uart_byte_t  rsp;
    logic [1:0]            code;
    cmd_pkg::read_result_t exp_read;
    int                    idle;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd         = '0;
    cmd_vld     = 1'b0;
    rsp_byte    = '0;
    rsp_code    = 2'd0;
    cycles      = 0;
    void'($urandom(32'h9825));
    for (int i = 0; i < 3 * max_cases; i++)
      stim_mem[i] = 20'hfffff;
    $readmemh("verif/uart_stimulus.txt", stim_mem);
    num_cases = 0;
    while (num_cases < max_cases && stim_mem[3*num_cases] != 20'hfffff)
      num_cases++;
    if (num_cases == 0)
      abort_run("stimulus file holds no cases");
    cycle_limit = num_cases * (3 * 11 * clks_per_bit + 2 * gap_cycles + 40) + 200;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_level("tx", tx, 1'b1);
    check_level("cmd_rdy", cmd_rdy, 1'b1);
    check_level("read_rdy", read_rdy, 1'b0);

    for (int k = 0; k < num_cases; k++)
    begin
      cmd_word = stim_mem[3*k][15:0];
      rsp      = stim_mem[3*k+1][7:0];
      code     = stim_mem[3*k+2][1:0];
      idle     = $urandom % 21;
      repeat (idle) @(negedge clk);
      check_level("cmd_rdy", cmd_rdy, 1'b1);
      check_level("tx", tx, 1'b1);
      @(posedge clk);
      expect_quiet($sformatf("before case %0d", k));
      @(negedge clk);
      rsp_byte = rsp;
      rsp_code = code;
      cmd      = cmd_word;
      cmd_vld  = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      // strobe while busy, must be ignored.
      repeat (5) @(negedge clk);
      check_level("cmd_rdy", cmd_rdy, 1'b0);
      cmd     = ~cmd_word;
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      cmd     = cmd_word;
      while (frame_q.size() < 2)
        @(negedge clk);
      check_frame("tx lo", cmd_word.bytes.lo);
      check_frame("tx hi", cmd_word.bytes.hi);
      if (cmd_word.fields.wr)
      begin
        while (!cmd_rdy)
          @(negedge clk);
      end
      else
      begin
        while (read_q.size() == 0)
          @(posedge clk);
        exp_read.data       = rsp;
        exp_read.parity_err = (code == 2'd1);
        exp_read.frame_err  = (code == 2'd2);
        check_read("read_result", read_q.pop_front(), exp_read);
        @(negedge clk);
      end
    end

    // long enough for any stray frame to show up.
    repeat (2 * uart_pkg::frame_bits * clks_per_bit) @(negedge clk);
    check_level("tx", tx, 1'b1);
    check_level("cmd_rdy", cmd_rdy, 1'b1);
    check_level("read_rdy", read_rdy, 1'b0);
    @(posedge clk);
    expect_quiet("after the last case");
    $display("All checks passed");
    $finish;
  end

endmodule

// File: verif/uart_line_model.sv
`timescale 1ns/1ps

module uart_line_model #(
  parameter int clks_per_bit = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 tx,
  output logic                 rx,
  input  uart_pkg::uart_byte_t rsp_byte,
  input  logic [1:0]           rsp_code,
  output logic                 frame_vld,
  output logic                 frame_start,
  output uart_pkg::uart_byte_t frame_data,
  output logic                 frame_par,
  output logic                 frame_stop
);

  int frame_cnt;

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // entered on the first falling edge that sees tx low.
  task automatic decode_frame();
    uart_pkg::uart_byte_t data;
    logic                 start_bit;
    logic                 par_bit;
    wait_cycles(clks_per_bit / 2 - 1);
    start_bit = tx;
    for (int i = 0; i < uart_pkg::data_bits; i++)
    begin
      wait_cycles(clks_per_bit);
      data[i] = tx;
    end
    wait_cycles(clks_per_bit);
    par_bit = tx;
    wait_cycles(clks_per_bit);
    frame_start = start_bit;
    frame_data  = data;
    frame_par   = par_bit;
    frame_stop  = tx;
    frame_vld   = 1'b1;
    wait_cycles(1);
    frame_vld = 1'b0;
  endtask

  // start, data lsb first, parity, stop.
  task automatic send_response();
    logic [uart_pkg::frame_bits-1:0] bits;
    logic                            par;
    par = ~^rsp_byte;
    if (rsp_code == 2'd1)
      par = ~par;
    bits = {(rsp_code != 2'd2), par, rsp_byte, 1'b0};
    wait_cycles(2 * clks_per_bit - 1);
    // one-cycle low pulse, must be dropped by the receiver.
    rx = 1'b0;
    wait_cycles(1);
    rx = 1'b1;
    wait_cycles(clks_per_bit - 1);
    for (int i = 0; i < uart_pkg::frame_bits; i++)
    begin
      rx = bits[i];
      wait_cycles(clks_per_bit);
    end
    rx = 1'b1;
  endtask

  initial
  begin
    rx          = 1'b1;
    frame_vld   = 1'b0;
    frame_start = 1'b1;
    frame_data  = '0;
    frame_par   = 1'b0;
    frame_stop  = 1'b1;
    frame_cnt   = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (!tx)
      begin
        decode_frame();
        frame_cnt++;
        // the high byte carries the write flag in its top bit.
        if (frame_cnt % 2 == 0 && !frame_data[7])
          send_response();
      end
    end
  end

endmodule

// File: verif/uart_stimulus.txt
// columns: command word, response byte, corruption code (0 good, 1 parity, 2 stop low)
// command bit 15 selects write (1) or read (0), the response byte is unused for writes
8a3c 00 0
1205 a5 0
ff00 00 0
0180 3c 1
4bff c3 2
0000 ff 0
c2d4 00 0
7e81 00 1
9999 00 0
3355 5a 2
a001 00 0
5dc0 81 0
